// ==== aes128_enc.f ====
logic/aes_pkg.sv
logic/aes_sbox.sv
logic/aes_round.sv
logic/aes_key_expander.sv
logic/aes_cipher_core.sv
logic/aes_block_in.sv
logic/aes_block_out.sv
logic/aes128_enc.sv
verif/aes128_enc_asserts.sv
verif/aes128_enc_tb.sv

// ==== Bender.yml ====
package:
  name: aes128_enc

sources:
  - logic/aes_pkg.sv
  - logic/aes_sbox.sv
  - logic/aes_round.sv
  - logic/aes_key_expander.sv
  - logic/aes_cipher_core.sv
  - logic/aes_block_in.sv
  - logic/aes_block_out.sv
  - logic/aes128_enc.sv
  - target: test
    files:
      - verif/aes128_enc_asserts.sv
      - verif/aes128_enc_tb.sv

// ==== verif/aes128_enc_tb.sv ====
`default_nettype none

module aes128_enc_tb;

	localparam int unsigned HALF_PERIOD = 4;
	localparam int unsigned RESET_CYCLES = 16;
	// blocks offered over the whole run including the one cut off by reset
	localparam int unsigned BLOCKS_SENT = 8;
	localparam int unsigned WATCHDOG_CYCLES = BLOCKS_SENT * 200 + 2 * RESET_CYCLES;

	// FIPS-197 appendix B, appendix C.1 and the all-zero vector
	localparam logic [127:0] KEY_B = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam logic [127:0] PT_B = 128'h3243f6a8885a308d313198a2e0370734;
	localparam logic [127:0] CT_B = 128'h3925841d02dc09fbdc118597196a0b32;
	localparam logic [127:0] KEY_C = 128'h000102030405060708090a0b0c0d0e0f;
	localparam logic [127:0] PT_C = 128'h00112233445566778899aabbccddeeff;
	localparam logic [127:0] CT_C = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam logic [127:0] CT_ZERO = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

	logic                clock_clk;
	logic                arst_n;
	logic                in_req;
	logic                in_ack;
	aes_pkg::aes_block_u plaintext;
	aes_pkg::aes_block_u key;
	logic                out_req;
	logic                out_ack;
	aes_pkg::aes_block_u ciphertext;

	logic [31:0] lfsr_q;
	int unsigned error_count;
	int unsigned check_count;
	int unsigned test_count;
	int unsigned assert_failures;

	aes128_enc aes128_enc_i (
		.clock_clk_i (clock_clk),
		.arst_n_i    (arst_n),
		.in_req_i    (in_req),
		.in_ack_o    (in_ack),
		.plaintext_i (plaintext),
		.key_i       (key),
		.out_req_o   (out_req),
		.out_ack_i   (out_ack),
		.ciphertext_o(ciphertext)
	);

	bind aes128_enc aes128_enc_asserts asserts_i (
		.clock_clk_i (clock_clk_i),
		.arst_n_i    (arst_n_i),
		.in_req_i    (in_req_i),
		.in_ack_i    (in_ack_o),
		.out_req_i   (out_req_o),
		.out_ack_i   (out_ack_i),
		.ciphertext_i(ciphertext_o)
	);

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int unsigned n, output int unsigned v);
		v = 0;
		for (int unsigned i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = (v << 1) | lfsr_q[0];
		end
	endtask

	task automatic check_block(input string name, input aes_pkg::aes_block_u got,
		input aes_pkg::aes_block_u exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	// source side of the input four-phase handshake
	task automatic send_block(input aes_pkg::aes_block_u pt, input aes_pkg::aes_block_u k);
		@(negedge clock_clk);
		plaintext = pt;
		key = k;
		in_req = 1'b1;
		do begin
			@(negedge clock_clk);
		end while (!in_ack);
		in_req = 1'b0;
		do begin
			@(negedge clock_clk);
		end while (in_ack);
	endtask

	// sink answers each request after a random delay
	task automatic take_block(output aes_pkg::aes_block_u ct);
		int unsigned delay;
		do begin
			@(negedge clock_clk);
		end while (!out_req);
		random_bits(5, delay);
		repeat (delay) @(negedge clock_clk);
		ct = ciphertext;
		out_ack = 1'b1;
		do begin
			@(negedge clock_clk);
		end while (out_req);
		out_ack = 1'b0;
	endtask

	task automatic encrypt_and_check(input aes_pkg::aes_block_u pt,
		input aes_pkg::aes_block_u k, input aes_pkg::aes_block_u exp);
		aes_pkg::aes_block_u ct;
		fork
			send_block(pt, k);
			take_block(ct);
		join
		check_block("ciphertext_o", ct, exp);
	endtask

	task automatic end_test(input string name, input int unsigned errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d failed checks", name, error_count - errors_before);
		end
	endtask

	task automatic test_fips_b();
		int unsigned errors_before;
		errors_before = error_count;
		encrypt_and_check(PT_B, KEY_B, CT_B);
		end_test("fips197 appendix b", errors_before);
	endtask

	task automatic test_fips_c();
		int unsigned errors_before;
		errors_before = error_count;
		encrypt_and_check(PT_C, KEY_C, CT_C);
		end_test("fips197 appendix c.1", errors_before);
	endtask

	// no key bits set, so only the round constants shape the schedule
	task automatic test_zero_key();
		int unsigned errors_before;
		errors_before = error_count;
		encrypt_and_check('0, '0, CT_ZERO);
		end_test("all-zero key and plaintext", errors_before);
	endtask

	task automatic test_backpressure_order();
		int unsigned         errors_before;
		aes_pkg::aes_block_u ct;
		aes_pkg::aes_block_u got_q[$];
		errors_before = error_count;
		fork
			begin
				send_block(PT_B, KEY_B);
				send_block(PT_C, KEY_C);
				send_block('0, '0);
			end
			begin
				for (int i = 0; i < 3; i++) begin
					take_block(ct);
					got_q.push_back(ct);
				end
			end
		join
		check_block("ciphertext_o", got_q[0], CT_B);
		check_block("ciphertext_o", got_q[1], CT_C);
		check_block("ciphertext_o", got_q[2], CT_ZERO);
		// a duplicate would sit here with out_req_o raised
		repeat (40) @(negedge clock_clk);
		check_bit("out_req_o", out_req, 1'b0);
		end_test("back-pressure and order", errors_before);
	endtask

	task automatic test_reset_mid_block();
		int unsigned errors_before;
		errors_before = error_count;
		send_block(PT_C, KEY_C);
		// core is now a few rounds into the block
		repeat (4) @(negedge clock_clk);
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clock_clk);
		check_bit("in_ack_o", in_ack, 1'b0);
		check_bit("out_req_o", out_req, 1'b0);
		arst_n = 1'b1;
		repeat (RESET_CYCLES) @(negedge clock_clk);
		check_bit("in_ack_o", in_ack, 1'b0);
		check_bit("out_req_o", out_req, 1'b0);
		encrypt_and_check(PT_B, KEY_B, CT_B);
		end_test("reset in mid-block", errors_before);
	endtask

	initial begin
		clock_clk = 1'b0;
		forever #HALF_PERIOD clock_clk = ~clock_clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock_clk);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		in_req = 1'b0;
		plaintext = '0;
		key = '0;
		out_ack = 1'b0;
		lfsr_q = 32'h1cbe_5e8f;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		assert_failures = 0;
		repeat (RESET_CYCLES) @(negedge clock_clk);
		arst_n = 1'b1;
		@(negedge clock_clk);
		test_fips_b();
		test_fips_c();
		test_zero_key();
		test_backpressure_order();
		test_reset_mid_block();
		assert_failures = aes128_enc_i.asserts_i.fail_count;
		$display("tests %0d, checks %0d, failed checks %0d, failed assertions %0d",
			test_count, check_count, error_count, assert_failures);
		if (error_count == 0 && assert_failures == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/aes128_enc_asserts.sv ====
`default_nettype none

module aes128_enc_asserts (
	input wire                      clock_clk_i,
	input wire                      arst_n_i,
	input wire                      in_req_i,
	input wire                      in_ack_i,
	input wire                      out_req_i,
	input wire                      out_ack_i,
	input wire aes_pkg::aes_block_u ciphertext_i
);

	// running count of failed assertions
	int unsigned fail_count = 0;

	// ack goes up only in answer to a pending request
	ack_rise_needs_req: assert property (@(posedge clock_clk_i) disable iff (!arst_n_i)
		$rose(in_ack_i) |-> $past(in_req_i))
		else begin
			fail_count++;
			$error("in_ack_o rose while in_req_i was low");
		end

	// ack comes down only once the source has let go of req
	ack_fall_after_req: assert property (@(posedge clock_clk_i) disable iff (!arst_n_i)
		$fell(in_ack_i) |-> $past(!in_req_i))
		else begin
			fail_count++;
			$error("in_ack_o fell while in_req_i was still high");
		end

	// output request held until the sink answers
	req_held_until_ack: assert property (@(posedge clock_clk_i) disable iff (!arst_n_i)
		out_req_i && !out_ack_i |=> out_req_i)
		else begin
			fail_count++;
			$error("out_req_o dropped before out_ack_i was seen");
		end

	// data must not move under a raised request
	data_stable_under_req: assert property (@(posedge clock_clk_i) disable iff (!arst_n_i)
		out_req_i && $past(out_req_i) |-> $stable(ciphertext_i))
		else begin
			fail_count++;
			$error("ciphertext_o changed while out_req_o was high");
		end

endmodule

`default_nettype wire

// ==== logic/aes128_enc.sv ====
`default_nettype none

module aes128_enc (
	input  wire                      clock_clk_i,
	input  wire                      arst_n_i,
	input  wire                      in_req_i,
	output logic                     in_ack_o,
	input  wire aes_pkg::aes_block_u plaintext_i,
	input  wire aes_pkg::aes_block_u key_i,
	output logic                     out_req_o,
	input  wire                      out_ack_i,
	output aes_pkg::aes_block_u      ciphertext_o
);

	logic                blk_valid;
	aes_pkg::aes_block_u blk_text;
	aes_pkg::aes_block_u blk_key;
	logic                core_ready;
	logic                res_valid;
	aes_pkg::aes_block_u res_text;
	logic                out_free;

	aes_block_in block_in_i (
		.clock_clk_i (clock_clk_i),
		.arst_n_i    (arst_n_i),
		.in_req_i    (in_req_i),
		.in_ack_o    (in_ack_o),
		.plaintext_i (plaintext_i),
		.key_i       (key_i),
		.blk_valid_o (blk_valid),
		.blk_text_o  (blk_text),
		.blk_key_o   (blk_key),
		.core_ready_i(core_ready)
	);

	// one block at a time in the iterating core
	aes_cipher_core cipher_core_i (
		.clock_clk_i (clock_clk_i),
		.arst_n_i    (arst_n_i),
		.blk_valid_i (blk_valid),
		.blk_text_i  (blk_text),
		.blk_key_i   (blk_key),
		.core_ready_o(core_ready),
		.res_valid_o (res_valid),
		.res_text_o  (res_text),
		.out_free_i  (out_free)
	);

	aes_block_out block_out_i (
		.clock_clk_i (clock_clk_i),
		.arst_n_i    (arst_n_i),
		.res_valid_i (res_valid),
		.res_text_i  (res_text),
		.out_free_o  (out_free),
		.out_req_o   (out_req_o),
		.out_ack_i   (out_ack_i),
		.ciphertext_o(ciphertext_o)
	);

endmodule

`default_nettype wire

// ==== logic/aes_block_out.sv ====
`default_nettype none

module aes_block_out (
	input  wire                      clock_clk_i,
	input  wire                      arst_n_i,
	input  wire                      res_valid_i,
	input  wire aes_pkg::aes_block_u res_text_i,
	output logic                     out_free_o,
	output logic                     out_req_o,
	input  wire                      out_ack_i,
	output aes_pkg::aes_block_u      ciphertext_o
);

	logic full_q;
	logic req_q;
	logic take;

	assign out_free_o = !full_q;
	assign take = res_valid_i && out_free_o;

	always_ff @(posedge clock_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			full_q <= 1'b0;
			req_q <= 1'b0;
		end else begin
			if (take) begin
				req_q <= 1'b1;
			end else if (req_q && out_ack_i) begin
				req_q <= 1'b0;
			end
			// stays full until the sink has released its ack
			if (take) begin
				full_q <= 1'b1;
			end else if (full_q && !req_q && !out_ack_i) begin
				full_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock_clk_i) begin
		if (take) begin
			ciphertext_o <= res_text_i;
		end
	end

	assign out_req_o = req_q;

endmodule

`default_nettype wire

// ==== logic/aes_block_in.sv ====
`default_nettype none

module aes_block_in (
	input  wire                      clock_clk_i,
	input  wire                      arst_n_i,
	input  wire                      in_req_i,
	output logic                     in_ack_o,
	input  wire aes_pkg::aes_block_u plaintext_i,
	input  wire aes_pkg::aes_block_u key_i,
	output logic                     blk_valid_o,
	output aes_pkg::aes_block_u      blk_text_o,
	output aes_pkg::aes_block_u      blk_key_o,
	input  wire                      core_ready_i
);

	logic ack_q;
	logic full_q;
	logic capture;

	// new request, previous handshake closed and register empty
	assign capture = in_req_i && !ack_q && !full_q;

	always_ff @(posedge clock_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
			full_q <= 1'b0;
		end else begin
			if (capture) begin
				ack_q <= 1'b1;
			end else if (ack_q && !in_req_i) begin
				ack_q <= 1'b0;
			end
			if (capture) begin
				full_q <= 1'b1;
			end else if (full_q && core_ready_i) begin
				full_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock_clk_i) begin
		if (capture) begin
			blk_text_o <= plaintext_i;
			blk_key_o <= key_i;
		end
	end

	assign in_ack_o = ack_q;
	assign blk_valid_o = full_q;

endmodule

`default_nettype wire

// ==== logic/aes_cipher_core.sv ====
`default_nettype none

module aes_cipher_core (
	input  wire                      clock_clk_i,
	input  wire                      arst_n_i,
	input  wire                      blk_valid_i,
	input  wire aes_pkg::aes_block_u blk_text_i,
	input  wire aes_pkg::aes_block_u blk_key_i,
	output logic                     core_ready_o,
	output logic                     res_valid_o,
	output aes_pkg::aes_block_u      res_text_o,
	input  wire                      out_free_i
);

	logic                busy_q;
	logic                done_q;
	aes_pkg::aes_round_t round_q;
	aes_pkg::aes_block_u state_q;
	aes_pkg::aes_block_u round_key;
	aes_pkg::aes_block_u round_out;
	logic                accept;
	logic                step;
	logic                final_round;

	assign core_ready_o = !busy_q;
	assign accept = blk_valid_i && core_ready_o;
	// one round per cycle until the result is parked
	assign step = busy_q && !done_q;
	assign final_round = round_q == aes_pkg::aes_round_t'(aes_pkg::AES_NR);

	aes_key_expander key_expander_i (
		.clock_clk_i(clock_clk_i),
		.arst_n_i   (arst_n_i),
		.load_i     (accept),
		.key_i      (blk_key_i),
		.step_i     (step),
		.round_key_o(round_key)
	);

	aes_round round_i (
		.state_i      (state_q),
		.round_key_i  (round_key),
		.final_round_i(final_round),
		.state_o      (round_out)
	);

	// whitening on accept, then the rounds
	always_ff @(posedge clock_clk_i) begin
		if (accept) begin
			state_q <= blk_text_i ^ blk_key_i;
		end else if (step) begin
			state_q <= round_out;
		end
	end

	always_ff @(posedge clock_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			round_q <= '0;
		end else if (accept) begin
			busy_q <= 1'b1;
			round_q <= aes_pkg::aes_round_t'(1);
		end else if (step) begin
			if (final_round) begin
				done_q <= 1'b1;
			end else begin
				round_q <= round_q + aes_pkg::aes_round_t'(1);
			end
		end else if (done_q && out_free_i) begin
			// result handed to the output port
			busy_q <= 1'b0;
			done_q <= 1'b0;
		end
	end

	assign res_valid_o = done_q;
	assign res_text_o = state_q;

endmodule

`default_nettype wire

// ==== logic/aes_key_expander.sv ====
`default_nettype none

module aes_key_expander (
	input  wire                      clock_clk_i,
	input  wire                      arst_n_i,
	input  wire                      load_i,
	input  wire aes_pkg::aes_block_u key_i,
	input  wire                      step_i,
	output aes_pkg::aes_block_u      round_key_o
);

	aes_pkg::aes_block_u           key_q;
	aes_pkg::aes_byte_t            rcon_q;
	aes_pkg::aes_byte_t [0:3]      sub_bytes;

	// RotWord then SubWord on the last word of the current key
	for (genvar i = 0; i < 4; i++) begin : g_sbox
		aes_sbox sbox_i (
			.byte_i(key_q.bytes[4*(aes_pkg::AES_NB - 1) + (i + 1) % 4]),
			.byte_o(sub_bytes[i])
		);
	end

	// next round key, each word chains on the one before
	always_comb begin
		round_key_o.words[0] = key_q.words[0] ^ sub_bytes ^ {rcon_q, 24'h000000};
		for (int i = 1; i < aes_pkg::AES_NB; i++) begin
			round_key_o.words[i] = key_q.words[i] ^ round_key_o.words[i-1];
		end
	end

	always_ff @(posedge clock_clk_i) begin
		if (load_i) begin
			key_q <= key_i;
		end else if (step_i) begin
			key_q <= round_key_o;
		end
	end

	always_ff @(posedge clock_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rcon_q <= aes_pkg::AES_RCON_INIT;
		end else if (load_i) begin
			rcon_q <= aes_pkg::AES_RCON_INIT;
		end else if (step_i) begin
			rcon_q <= aes_pkg::aes_xtime(rcon_q);
		end
	end

endmodule

`default_nettype wire

// ==== logic/aes_round.sv ====
`default_nettype none

module aes_round (
	input  wire aes_pkg::aes_block_u state_i,
	input  wire aes_pkg::aes_block_u round_key_i,
	input  wire                      final_round_i,
	output aes_pkg::aes_block_u      state_o
);

	// one column through the MixColumns matrix
	function automatic aes_pkg::aes_word_t mix_column(input aes_pkg::aes_word_t col);
		aes_pkg::aes_byte_t a0;
		aes_pkg::aes_byte_t a1;
		aes_pkg::aes_byte_t a2;
		aes_pkg::aes_byte_t a3;
		aes_pkg::aes_byte_t x0;
		aes_pkg::aes_byte_t x1;
		aes_pkg::aes_byte_t x2;
		aes_pkg::aes_byte_t x3;
		{a0, a1, a2, a3} = col;
		x0 = aes_pkg::aes_xtime(a0);
		x1 = aes_pkg::aes_xtime(a1);
		x2 = aes_pkg::aes_xtime(a2);
		x3 = aes_pkg::aes_xtime(a3);
		return {x0 ^ x1 ^ a1 ^ a2 ^ a3, a0 ^ x1 ^ x2 ^ a2 ^ a3,
			a0 ^ a1 ^ x2 ^ x3 ^ a3, x0 ^ a0 ^ a1 ^ a2 ^ x3};
	endfunction

	aes_pkg::aes_block_u sub_state;
	aes_pkg::aes_block_u shift_state;
	aes_pkg::aes_block_u mix_state;

	for (genvar i = 0; i < aes_pkg::AES_BLOCK_W / aes_pkg::AES_BYTE_W; i++) begin : g_sbox
		aes_sbox sbox_i (
			.byte_i(state_i.bytes[i]),
			.byte_o(sub_state.bytes[i])
		);
	end

	// row r of column c comes from column c+r
	always_comb begin
		for (int c = 0; c < aes_pkg::AES_NB; c++) begin
			for (int r = 0; r < 4; r++) begin
				shift_state.bytes[4*c + r] = sub_state.bytes[4*((c + r) % 4) + r];
			end
		end
	end

	always_comb begin
		for (int c = 0; c < aes_pkg::AES_NB; c++) begin
			mix_state.words[c] = mix_column(shift_state.words[c]);
		end
	end

	// last round has no MixColumns
	assign state_o = (final_round_i ? shift_state : mix_state) ^ round_key_i;

endmodule

`default_nettype wire

// ==== logic/aes_sbox.sv ====
`default_nettype none

module aes_sbox (
	input  wire aes_pkg::aes_byte_t byte_i,
	output aes_pkg::aes_byte_t      byte_o
);

	// product of two GF(2^4) elements
	function automatic logic [3:0] gf4_mul(input logic [3:0] x, input logic [3:0] y);
		logic [3:0] m;
		m[0] = (x[0] & y[0]) ^ (x[3] & y[1]) ^ (x[2] & y[2]) ^ (x[1] & y[3]);
		m[1] = (x[1] & y[0]) ^ ((x[0] ^ x[3]) & y[1]) ^ ((x[2] ^ x[3]) & y[2])
			^ ((x[1] ^ x[2]) & y[3]);
		m[2] = (x[2] & y[0]) ^ (x[1] & y[1]) ^ ((x[0] ^ x[3]) & y[2])
			^ ((x[2] ^ x[3]) & y[3]);
		m[3] = (x[3] & y[0]) ^ (x[2] & y[1]) ^ (x[1] & y[2]) ^ ((x[0] ^ x[3]) & y[3]);
		return m;
	endfunction

	logic       map_a;
	logic       map_b;
	logic       map_c;
	logic [3:0] ah;
	logic [3:0] al;
	logic [3:0] sq_h;
	logic [3:0] sq_l;
	logic [3:0] sq_he;
	logic [3:0] xin;
	logic       inv_a;
	logic [3:0] inv;
	logic [3:0] qmh;
	logic [3:0] qml;
	logic       back_a;
	logic       back_b;
	logic [7:0] gf;
	logic       aff_a;
	logic       aff_b;
	logic       aff_c;
	logic       aff_d;

	// isomorphic map into GF(2^4)^2, byte = ah*x + al
	assign map_a = byte_i[1] ^ byte_i[7];
	assign map_b = byte_i[5] ^ byte_i[7];
	assign map_c = byte_i[4] ^ byte_i[6];
	assign al = {byte_i[2] ^ byte_i[4], map_a, byte_i[1] ^ byte_i[2],
		map_c ^ byte_i[0] ^ byte_i[5]};
	assign ah = {map_b, map_b ^ byte_i[2] ^ byte_i[3], map_a ^ map_c, map_c ^ byte_i[5]};

	// squares of both halves
	assign sq_h = {ah[3], ah[1] ^ ah[3], ah[2], ah[0] ^ ah[2]};
	assign sq_l = {al[3], al[1] ^ al[3], al[2], al[0] ^ al[2]};

	// high square times the constant e
	assign sq_he[0] = sq_h[1] ^ sq_h[2] ^ sq_h[3];
	assign sq_he[1] = sq_h[0] ^ sq_h[1];
	assign sq_he[2] = sq_h[0] ^ sq_h[1] ^ sq_h[2];
	assign sq_he[3] = sq_h[0] ^ sq_h[1] ^ sq_h[2] ^ sq_h[3];

	assign xin = sq_he ^ sq_l ^ gf4_mul(ah, al);

	// GF(2^4) inverse
	assign inv_a = xin[1] ^ xin[2] ^ xin[3] ^ (xin[1] & xin[2] & xin[3]);
	assign inv[0] = inv_a ^ xin[0] ^ (xin[0] & xin[2]) ^ (xin[1] & xin[2])
		^ (xin[0] & xin[1] & xin[2]);
	assign inv[1] = (xin[0] & xin[1]) ^ (xin[0] & xin[2]) ^ (xin[1] & xin[2]) ^ xin[3]
		^ (xin[1] & xin[3]) ^ (xin[0] & xin[1] & xin[3]);
	assign inv[2] = (xin[0] & xin[1]) ^ xin[2] ^ (xin[0] & xin[2]) ^ xin[3]
		^ (xin[0] & xin[3]) ^ (xin[0] & xin[2] & xin[3]);
	assign inv[3] = inv_a ^ (xin[0] & xin[3]) ^ (xin[1] & xin[3]) ^ (xin[2] & xin[3]);

	assign qmh = gf4_mul(ah, inv);
	assign qml = gf4_mul(ah ^ al, inv);

	// inverse map back to GF(2^8)
	assign back_a = qml[1] ^ qmh[3];
	assign back_b = qmh[0] ^ qmh[1];
	assign gf[0] = qml[0] ^ qmh[0];
	assign gf[1] = back_b ^ qmh[3];
	assign gf[2] = back_a ^ back_b;
	assign gf[3] = back_b ^ qml[1] ^ qmh[2];
	assign gf[4] = back_a ^ back_b ^ qml[3];
	assign gf[5] = back_b ^ qml[2];
	assign gf[6] = back_a ^ qml[2] ^ qml[3] ^ qmh[0];
	assign gf[7] = back_b ^ qml[2] ^ qmh[3];

	// affine stage, constant 63h folded in at the end
	assign aff_a = gf[0] ^ gf[1];
	assign aff_b = gf[2] ^ gf[3];
	assign aff_c = gf[4] ^ gf[5];
	assign aff_d = gf[6] ^ gf[7];
	assign byte_o = {gf[3] ^ aff_c ^ aff_d, gf[6] ^ aff_b ^ aff_c, gf[1] ^ aff_b ^ aff_c,
		gf[4] ^ aff_a ^ aff_b, gf[7] ^ aff_a ^ aff_b, gf[2] ^ aff_a ^ aff_d,
		gf[5] ^ aff_a ^ aff_d, gf[0] ^ aff_c ^ aff_d} ^ 8'h63;

endmodule

`default_nettype wire

// ==== logic/aes_pkg.sv ====
`default_nettype none

package aes_pkg;

	// fixed AES-128 sizes
	localparam int unsigned AES_NB = 4;
	localparam int unsigned AES_NR = 10;
	localparam int unsigned AES_BLOCK_W = 128;
	localparam int unsigned AES_WORD_W = 32;
	localparam int unsigned AES_BYTE_W = 8;

	typedef logic [AES_BYTE_W-1:0] aes_byte_t;
	typedef logic [AES_WORD_W-1:0] aes_word_t;

	// counts 0 up to AES_NR
	typedef logic [$clog2(AES_NR+1)-1:0] aes_round_t;

	// first round constant
	localparam aes_byte_t AES_RCON_INIT = 8'h01;

	// low byte of x^8 + x^4 + x^3 + x + 1
	localparam aes_byte_t AES_REDUCE = 8'h1b;

	// one 128-bit block, byte 0 and word 0 sit at the top end as in FIPS-197
	// bytes for SubBytes and ShiftRows, words for MixColumns and the key schedule
	typedef union packed {
		aes_byte_t [0:AES_BLOCK_W/AES_BYTE_W-1] bytes;
		aes_word_t [0:AES_NB-1]                 words;
	} aes_block_u;

	// multiply by x in GF(2^8)
	function automatic aes_byte_t aes_xtime(input aes_byte_t b);
		aes_byte_t shifted;
		shifted = {b[AES_BYTE_W-2:0], 1'b0};
		return b[AES_BYTE_W-1] ? (shifted ^ AES_REDUCE) : shifted;
	endfunction

endpackage

`default_nettype wire
